// File: Bender.yml
package:
  name: soc_wb8

sources:
  - rtl/soc_pkg.sv
  - rtl/wb8_if.sv
  - rtl/bus_decoder.sv
  - rtl/ram_wb8.sv
  - rtl/leds_wb8.sv
  - rtl/timer_wb8.sv
  - rtl/uart_tx_wb8.sv
  - rtl/soc_top.sv
  - target: test
    files:
      - verification/soc_tb.sv

// File: rtl/bus_decoder.sv
`default_nettype none

module bus_decoder (
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [soc_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [soc_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [soc_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                        wb_ack_o,
    wb8_if.master                       ram_bus,
    wb8_if.master                       uart_bus,
    wb8_if.master                       timer_bus,
    wb8_if.master                       leds_bus
);

    soc_pkg::slave_sel_e sel;

    // region first, then the I/O page
    always_comb begin
        sel = soc_pkg::SEL_RAM;
        if (wb_adr_i[soc_pkg::ADDR_W-1:11] == soc_pkg::IO_PAGE_TAG) begin
            case (wb_adr_i[10:8])
                soc_pkg::UART_PAGE:  sel = soc_pkg::SEL_UART;
                soc_pkg::TIMER_PAGE: sel = soc_pkg::SEL_TIMER;
                // unused pages land on the leds
                default:             sel = soc_pkg::SEL_LEDS;
            endcase
        end
    end

    // strobe reaches the selected slave only
    assign ram_bus.stb   = wb_stb_i && (sel == soc_pkg::SEL_RAM);
    assign uart_bus.stb  = wb_stb_i && (sel == soc_pkg::SEL_UART);
    assign timer_bus.stb = wb_stb_i && (sel == soc_pkg::SEL_TIMER);
    assign leds_bus.stb  = wb_stb_i && (sel == soc_pkg::SEL_LEDS);

    // shared lines fan out to every slave
    assign ram_bus.we      = wb_we_i;
    assign ram_bus.adr     = wb_adr_i[soc_pkg::SLV_ADR_W-1:0];
    assign ram_bus.dat_w   = wb_dat_i;
    assign uart_bus.we     = wb_we_i;
    assign uart_bus.adr    = wb_adr_i[soc_pkg::SLV_ADR_W-1:0];
    assign uart_bus.dat_w  = wb_dat_i;
    assign timer_bus.we    = wb_we_i;
    assign timer_bus.adr   = wb_adr_i[soc_pkg::SLV_ADR_W-1:0];
    assign timer_bus.dat_w = wb_dat_i;
    assign leds_bus.we     = wb_we_i;
    assign leds_bus.adr    = wb_adr_i[soc_pkg::SLV_ADR_W-1:0];
    assign leds_bus.dat_w  = wb_dat_i;

    // return path from the selected slave
    always_comb begin
        case (sel)
            soc_pkg::SEL_UART: begin
                wb_dat_o = uart_bus.dat_r;
                wb_ack_o = uart_bus.ack;
            end
            soc_pkg::SEL_TIMER: begin
                wb_dat_o = timer_bus.dat_r;
                wb_ack_o = timer_bus.ack;
            end
            soc_pkg::SEL_LEDS: begin
                wb_dat_o = leds_bus.dat_r;
                wb_ack_o = leds_bus.ack;
            end
            default: begin
                wb_dat_o = ram_bus.dat_r;
                wb_ack_o = ram_bus.ack;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/leds_wb8.sv
`default_nettype none

module leds_wb8 (
    input  logic                       clk,
    input  logic                       reset_i,
    wb8_if.slave                       bus,
    output logic [soc_pkg::DATA_W-1:0] leds_o
);

    logic [soc_pkg::DATA_W-1:0] leds_q;
    logic                       ack_q;
    logic                       start;

    assign start = bus.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            leds_q <= '0;
        end else begin
            ack_q <= start;
            if (start && bus.we) begin
                leds_q <= bus.dat_w;
            end
        end
    end

    // register value is visible on the pins and on reads
    assign bus.dat_r = leds_q;
    assign bus.ack   = ack_q;
    assign leds_o    = leds_q;

endmodule

`default_nettype wire

// File: rtl/ram_wb8.sv
`default_nettype none

module ram_wb8 #(
    parameter int RAM_DEPTH = 1024
) (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus
);

    localparam int IDX_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    logic [soc_pkg::DATA_W-1:0] mem [RAM_DEPTH];
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]           idx;
    logic                       ack_q;
    logic                       start;

    // addresses past the array wrap around
    assign idx   = IDX_W'(bus.adr % RAM_DEPTH);
    // new request seen while ack is low
    assign start = bus.stb && !ack_q;

    // write and read both happen on the ack edge
    always_ff @(posedge clk) begin
        if (start) begin
            if (bus.we) begin
                mem[idx] <= bus.dat_w;
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

// File: rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 8;
    // only the low address bits reach a slave
    localparam int SLV_ADR_W = 10;

    // I/O region is the top 2 KiB with pages picked by bits 10..8
    localparam logic [20:0] IO_PAGE_TAG = 21'h1F_FFFF;
    localparam logic [2:0]  UART_PAGE   = 3'd0;
    localparam logic [2:0]  TIMER_PAGE  = 3'd5;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_UART,
        SEL_TIMER,
        SEL_LEDS
    } slave_sel_e;

    typedef enum logic [1:0] {
        TMR_CTRL   = 2'd0,
        TMR_RELOAD = 2'd1,
        TMR_COUNT  = 2'd2
    } timer_reg_e;

    typedef enum logic {
        UART_DATA   = 1'b0,
        UART_STATUS = 1'b1
    } uart_reg_e;

    // bits of TMR_CTRL
    localparam int TIMER_EN_BIT    = 0;
    localparam int TIMER_IRQEN_BIT = 1;
    localparam int TIMER_EXP_BIT   = 2;

endpackage

`default_nettype wire

// File: rtl/soc_top.sv
`default_nettype none

module soc_top #(
    parameter int RAM_DEPTH    = 1024,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                       clk,
    input  logic                       reset_i,
    // bus from the external master
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [soc_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [soc_pkg::DATA_W-1:0] wb_dat_i,
    output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
    output logic                       wb_ack_o,
    // peripheral pins
    output logic [soc_pkg::DATA_W-1:0] leds_o,
    output logic                       uart_tx_o,
    output logic                       timer_irq_o
);

    // one bus per slave
    wb8_if ram_if ();
    wb8_if uart_if ();
    wb8_if timer_if ();
    wb8_if leds_if ();

    bus_decoder u_decoder (
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .ram_bus   (ram_if.master),
        .uart_bus  (uart_if.master),
        .timer_bus (timer_if.master),
        .leds_bus  (leds_if.master)
    );

    ram_wb8 #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (ram_if.slave)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (leds_if.slave),
        .leds_o  (leds_o)
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (timer_if.slave),
        .irq_o   (timer_irq_o)
    );

    uart_tx_wb8 #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (uart_if.slave),
        .tx_o    (uart_tx_o)
    );

endmodule

`default_nettype wire

// File: rtl/timer_wb8.sv
`default_nettype none

module timer_wb8 (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus,
    output logic irq_o
);

    soc_pkg::timer_reg_e        reg_sel;
    logic [soc_pkg::DATA_W-1:0] reload_q;
    logic [soc_pkg::DATA_W-1:0] count_q;
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic [soc_pkg::DATA_W-1:0] ctrl;
    logic                       en_q;
    logic                       irqen_q;
    logic                       exp_q;
    logic                       ack_q;
    logic                       start;
    logic                       wr;

    assign start   = bus.stb && !ack_q;
    assign wr      = start && bus.we;
    assign reg_sel = soc_pkg::timer_reg_e'(bus.adr[1:0]);

    // control register as seen on a read
    always_comb begin
        ctrl                           = '0;
        ctrl[soc_pkg::TIMER_EN_BIT]    = en_q;
        ctrl[soc_pkg::TIMER_IRQEN_BIT] = irqen_q;
        ctrl[soc_pkg::TIMER_EXP_BIT]   = exp_q;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            en_q     <= 1'b0;
            irqen_q  <= 1'b0;
            exp_q    <= 1'b0;
            reload_q <= '0;
            count_q  <= '0;
        end else begin
            ack_q <= start;
            // count down, reload and flag at zero
            if (en_q) begin
                if (count_q == '0) begin
                    count_q <= reload_q;
                    exp_q   <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
            // bus writes take priority over the counter
            if (wr) begin
                case (reg_sel)
                    soc_pkg::TMR_CTRL: begin
                        en_q    <= bus.dat_w[soc_pkg::TIMER_EN_BIT];
                        irqen_q <= bus.dat_w[soc_pkg::TIMER_IRQEN_BIT];
                        // write one to clear
                        if (bus.dat_w[soc_pkg::TIMER_EXP_BIT]) begin
                            exp_q <= 1'b0;
                        end
                        if (bus.dat_w[soc_pkg::TIMER_EN_BIT]) begin
                            count_q <= reload_q;
                        end
                    end
                    soc_pkg::TMR_RELOAD: reload_q <= bus.dat_w;
                    soc_pkg::TMR_COUNT:  count_q  <= bus.dat_w;
                    default: ;
                endcase
            end
        end
    end

    // read data captured on the ack edge
    always_ff @(posedge clk) begin
        if (start) begin
            case (reg_sel)
                soc_pkg::TMR_CTRL:   rdata_q <= ctrl;
                soc_pkg::TMR_RELOAD: rdata_q <= reload_q;
                soc_pkg::TMR_COUNT:  rdata_q <= count_q;
                default:             rdata_q <= '0;
            endcase
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;
    assign irq_o     = exp_q && irqen_q;

endmodule

`default_nettype wire

// File: rtl/uart_tx_wb8.sv
`default_nettype none

module uart_tx_wb8 #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic reset_i,
    wb8_if.slave bus,
    output logic tx_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e                  state_q;
    soc_pkg::uart_reg_e         reg_sel;
    logic [CNT_W-1:0]           clk_cnt_q;
    logic [2:0]                 bit_idx_q;
    logic [soc_pkg::DATA_W-1:0] shift_q;
    logic [soc_pkg::DATA_W-1:0] data_q;
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic                       tx_q;
    logic                       ack_q;
    logic                       start;
    logic                       launch;
    logic                       busy;
    logic                       bit_done;

    assign start    = bus.stb && !ack_q;
    assign reg_sel  = soc_pkg::uart_reg_e'(bus.adr[0]);
    assign busy     = (state_q != TX_IDLE);
    assign bit_done = (clk_cnt_q == CNT_LAST);
    // writes while a frame is running are dropped
    assign launch   = start && bus.we && (reg_sel == soc_pkg::UART_DATA) && !busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= TX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= start;
            // bit timer runs in every state but idle
            if (state_q != TX_IDLE) begin
                clk_cnt_q <= bit_done ? '0 : clk_cnt_q + 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (launch) begin
                        state_q   <= TX_START;
                        clk_cnt_q <= '0;
                        tx_q      <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state_q   <= TX_DATA;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx_q == 3'd7) begin
                            state_q <= TX_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // byte to send goes out lsb first
    always_ff @(posedge clk) begin
        if (launch) begin
            data_q  <= bus.dat_w;
            shift_q <= bus.dat_w;
        end else if (state_q == TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (reg_sel == soc_pkg::UART_STATUS) begin
                rdata_q <= {{(soc_pkg::DATA_W-1){1'b0}}, busy};
            end else begin
                rdata_q <= data_q;
            end
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;
    assign tx_o      = tx_q;

endmodule

`default_nettype wire

// File: rtl/wb8_if.sv
`default_nettype none

interface wb8_if;

    logic                          stb;
    logic                          we;
    logic [soc_pkg::SLV_ADR_W-1:0] adr;
    logic [soc_pkg::DATA_W-1:0]    dat_w;
    logic [soc_pkg::DATA_W-1:0]    dat_r;
    logic                          ack;

    // decoder side
    modport master (
        output stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // peripheral side
    modport slave (
        input  stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: verification/soc_tb.sv
`default_nettype none

module soc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam logic [31:0] UART_BASE  = {soc_pkg::IO_PAGE_TAG, soc_pkg::UART_PAGE, 8'h00};
    localparam logic [31:0] TIMER_BASE = {soc_pkg::IO_PAGE_TAG, soc_pkg::TIMER_PAGE, 8'h00};
    localparam logic [31:0] LEDS_ADDR  = {soc_pkg::IO_PAGE_TAG, 3'd7, 8'h00};
    localparam logic [31:0] SPARE_ADDR = {soc_pkg::IO_PAGE_TAG, 3'd2, 8'h00};
    // bus transfers of the ram, leds, timer, masked timer and uart tests
    localparam int XFERS = 66 + 3 + 5 + 8 + 4;
    // wait bounds of the two timer tests, one uart frame and the idle wait
    localparam int WAITS = 20 + 20 + 10 * 8 + 8;
    localparam int BUDGET_CYCLES = ((16 + 3 * XFERS + WAITS) * 12) / 10;

    logic        clk;
    logic        reset_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [7:0]  wb_dat_i;
    logic [7:0]  wb_dat_o;
    logic        wb_ack_o;
    logic [7:0]  leds_o;
    logic        uart_tx_o;
    logic        timer_irq_o;

    logic [7:0]  ram_model [1024];
    integer      seed = 34620;
    int          pass_count = 0;
    int          error_count = 0;

    soc_top #(
        .RAM_DEPTH    (1024),
        .CLKS_PER_BIT (8)
    ) DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .leds_o      (leds_o),
        .uart_tx_o   (uart_tx_o),
        .timer_irq_o (timer_irq_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    // strobe held until ack and dropped on the next edge
    task automatic bus_transfer(input logic we, input logic [31:0] adr,
                                input logic [7:0] wdata, output logic [7:0] rdata);
        bit acked;
        int i;
        @(posedge clk);
        #2;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        acked    = 1'b0;
        rdata    = '0;
        for (i = 0; i < 4 && !acked; i++) begin
            @(negedge clk);
            if (wb_ack_o) begin
                acked = 1'b1;
                rdata = wb_dat_o;
            end
        end
        @(posedge clk);
        #2;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!acked) begin
            $display("bus %s at 0x%08h got no acknowledge within 4 cycles",
                     we ? "write" : "read", adr);
            error_count++;
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        bus_transfer(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [7:0] data);
        bus_transfer(1'b0, adr, 8'h00, data);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_ram;
        logic [9:0] addrs [32];
        logic [9:0] n;
        logic [7:0] data;
        logic [7:0] rd;
        int         i;
        int         errs;
        errs = error_count;
        for (i = 0; i < 32; i++) begin
            addrs[i] = $random(seed);
            data     = $random(seed);
            ram_model[addrs[i]] = data;
            bus_write({22'd0, addrs[i]}, data);
        end
        for (i = 0; i < 32; i++) begin
            bus_read({22'd0, addrs[i]}, rd);
            check_value("ram readback", ram_model[addrs[i]], rd);
        end
        // 0x400 + n wraps onto n
        n    = $random(seed);
        data = $random(seed);
        ram_model[n] = data;
        bus_write(32'h400 + n, data);
        bus_read({22'd0, n}, rd);
        check_value("ram alias", ram_model[n], rd);
        report_test("ram", errs);
    endtask

    task automatic test_leds;
        logic [7:0] data;
        logic [7:0] rd;
        int         errs;
        errs = error_count;
        data = $random(seed);
        bus_write(LEDS_ADDR, data);
        check_value("leds pins", data, leds_o);
        bus_read(LEDS_ADDR, rd);
        check_value("leds readback", data, rd);
        // unused io page falls through to the leds
        bus_write(SPARE_ADDR, ~data);
        check_value("leds spare page", ~data, leds_o);
        report_test("leds", errs);
    endtask

    task automatic test_timer_irq;
        logic [7:0] ctrl;
        logic [7:0] rd;
        int         i;
        int         errs;
        errs = error_count;
        bus_write(TIMER_BASE + soc_pkg::TMR_RELOAD, 8'd5);
        ctrl = '0;
        ctrl[soc_pkg::TIMER_EN_BIT]    = 1'b1;
        ctrl[soc_pkg::TIMER_IRQEN_BIT] = 1'b1;
        bus_write(TIMER_BASE + soc_pkg::TMR_CTRL, ctrl);
        for (i = 0; i < 20 && !timer_irq_o; i++) begin
            @(negedge clk);
        end
        check_value("timer irq raised", 8'd1, timer_irq_o);
        bus_read(TIMER_BASE + soc_pkg::TMR_CTRL, rd);
        check_value("timer expiry bit", 8'd1, rd[soc_pkg::TIMER_EXP_BIT]);
        // stop the count and clear the flag in one write
        ctrl = '0;
        ctrl[soc_pkg::TIMER_IRQEN_BIT] = 1'b1;
        ctrl[soc_pkg::TIMER_EXP_BIT]   = 1'b1;
        bus_write(TIMER_BASE + soc_pkg::TMR_CTRL, ctrl);
        check_value("timer irq cleared", 8'd0, timer_irq_o);
        bus_read(TIMER_BASE + soc_pkg::TMR_RELOAD, rd);
        check_value("timer reload", 8'd5, rd);
        report_test("timer_irq", errs);
    endtask

    task automatic test_timer_masked;
        logic [7:0] ctrl;
        logic [7:0] rd;
        int         i;
        int         errs;
        errs = error_count;
        ctrl = '0;
        ctrl[soc_pkg::TIMER_EN_BIT]  = 1'b1;
        ctrl[soc_pkg::TIMER_EXP_BIT] = 1'b1;
        bus_write(TIMER_BASE + soc_pkg::TMR_CTRL, ctrl);
        // poll for the flag while irq stays low
        rd = '0;
        for (i = 0; i < 7 && !rd[soc_pkg::TIMER_EXP_BIT]; i++) begin
            bus_read(TIMER_BASE + soc_pkg::TMR_CTRL, rd);
            check_value("timer irq masked", 8'd0, timer_irq_o);
        end
        check_value("timer masked expiry", 8'd1, rd[soc_pkg::TIMER_EXP_BIT]);
        report_test("timer_masked", errs);
    endtask

    task automatic test_uart;
        logic [7:0] data;
        logic [7:0] rd;
        logic [9:0] bits;
        int         b;
        int         errs;
        errs = error_count;
        data = $random(seed);
        fork
            begin
                // sample near the middle of each bit
                @(negedge uart_tx_o);
                repeat (4) @(negedge clk);
                for (b = 0; b < 10; b++) begin
                    bits[b] = uart_tx_o;
                    if (b < 9) begin
                        repeat (8) @(negedge clk);
                    end
                end
            end
            begin
                bus_write(UART_BASE + soc_pkg::UART_DATA, data);
                bus_read(UART_BASE + soc_pkg::UART_STATUS, rd);
                check_value("uart busy", 8'h01, rd);
                // dropped while the frame runs
                bus_write(UART_BASE + soc_pkg::UART_DATA, ~data);
            end
        join
        check_value("uart start bit", 8'd0, bits[0]);
        check_value("uart data bits", data, bits[8:1]);
        check_value("uart stop bit", 8'd1, bits[9]);
        repeat (8) @(posedge clk);
        bus_read(UART_BASE + soc_pkg::UART_STATUS, rd);
        check_value("uart idle", 8'h00, rd);
        report_test("uart", errs);
    endtask

    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", BUDGET_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        reset_i  = 1'b1;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;
        test_ram();
        test_leds();
        test_timer_irq();
        test_timer_masked();
        test_uart();
        $display("checks passed %0d, errors %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/soc_pkg.sv
rtl/wb8_if.sv
rtl/bus_decoder.sv
rtl/ram_wb8.sv
rtl/leds_wb8.sv
rtl/timer_wb8.sv
rtl/uart_tx_wb8.sv
rtl/soc_top.sv
verification/soc_tb.sv
